/* lstmCell.f */
hdl/lstmFixedPkg.sv
hdl/lstmControlPkg.sv
hdl/gateAccumulator.sv
hdl/cellUpdate.sv
hdl/cellStateStore.sv
hdl/lstmCell.sv
verification/clockGen.sv
verification/lstmCellTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module lstmCellTb \
    -f lstmCell.f -o lstmCellSim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/lstmCellSim > sim.log 2>&1 || true
cat sim.log
grep -q "TB FAILED" sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
exit 0

/* verification/lstmCellTb.sv */
`timescale 1ns/1ps

module lstmCellTb
    import lstmFixedPkg::*, lstmControlPkg::*;
();

    localparam int INPUT_SZ       = 2;
    localparam int HIDDEN_SZ      = 4;
    localparam int COLUMNS        = INPUT_SZ + HIDDEN_SZ + 1;
    localparam int ROW_BITS       = (HIDDEN_SZ > 1) ? $clog2(HIDDEN_SZ) : 1;
    localparam int COLUMN_BITS    = $clog2(COLUMNS);
    localparam int LATENCY        = INPUT_SZ + HIDDEN_SZ + 6;
    localparam int SHIFT          = 11;
    localparam int UNIT           = 2048;
    localparam int HALF_UNIT      = 1024;
    localparam int WORD_MAX       = 131071;
    localparam int WORD_MIN       = -131072;
    localparam int STEP_COUNT     = 20;
    localparam int WRITE_CYCLES   = 2 * 4 * HIDDEN_SZ * COLUMNS;
    localparam int TIMEOUT_CYCLES = (STEP_COUNT * LATENCY + WRITE_CYCLES) * 2;

    logic                   clock;
    logic                   reset;
    logic                   newSample;
    fixedT                  inputVec [INPUT_SZ];
    logic                   clearState;
    logic                   weightWrite;
    gateIndexT              weightGate;
    logic [ROW_BITS-1:0]    weightRow;
    logic [COLUMN_BITS-1:0] weightColumn;
    fixedT                  weightData;
    logic                   dataoutReady;
    fixedT                  outputVec [HIDDEN_SZ];

    int modelWeights [4][HIDDEN_SZ][COLUMNS];
    int modelCell [HIDDEN_SZ];
    int modelHidden [HIDDEN_SZ];
    int stimulus [INPUT_SZ];
    int cycleCount = 0;

    clockGen #(.PERIOD_NS(4), .RESET_CYCLES(2)) clockGen_inst (.clock(clock), .reset(reset));

    lstmCell #(
        .INPUT_SZ  (INPUT_SZ),
        .HIDDEN_SZ (HIDDEN_SZ)
    ) lstmCell_inst (
        .clock        (clock),
        .reset        (reset),
        .newSample    (newSample),
        .inputVec     (inputVec),
        .clearState   (clearState),
        .weightWrite  (weightWrite),
        .weightGate   (weightGate),
        .weightRow    (weightRow),
        .weightColumn (weightColumn),
        .weightData   (weightData),
        .dataoutReady (dataoutReady),
        .outputVec    (outputVec)
    );

    function automatic int clampToWord(input longint value);
        if (value > WORD_MAX)
            return WORD_MAX;
        if (value < WORD_MIN)
            return WORD_MIN;
        return int'(value);
    endfunction

    function automatic int floorNarrow(input longint value);
        return clampToWord(value >>> SHIFT);
    endfunction

    function automatic int sigmoidModel(input int x);
        int s;
        s = (x >>> 2) + HALF_UNIT;
        return (s < 0) ? 0 : ((s > UNIT) ? UNIT : s);
    endfunction

    function automatic int tanhModel(input int x);
        return (x > UNIT) ? UNIT : ((x < -UNIT) ? -UNIT : x);
    endfunction

    function automatic int randomRange(input int limit);
        return int'($urandom_range(2 * limit)) - limit;
    endfunction

    task automatic checkValue(input longint expected, input longint actual, input string what);
        if (expected !== actual)
        begin
            $display("Error at %0t ns: %s expected %0d got %0d", $time, what, expected, actual);
            $display("TB FAILED");
            $fatal(1, "Mismatch");
        end
    endtask

    // One cell step of the reference, all gates use the previous hidden state
    task automatic modelStep();
        longint acc;
        int     pre [4][HIDDEN_SZ];
        int     inputTerm;
        int     forgetTerm;
        for (int g = 0; g < 4; g++)
        begin
            for (int r = 0; r < HIDDEN_SZ; r++)
            begin
                acc = longint'(modelWeights[g][r][COLUMNS-1]) <<< SHIFT;
                for (int c = 0; c < INPUT_SZ; c++)
                    acc += longint'(modelWeights[g][r][c]) * stimulus[c];
                for (int c = 0; c < HIDDEN_SZ; c++)
                    acc += longint'(modelWeights[g][r][INPUT_SZ+c]) * modelHidden[c];
                pre[g][r] = floorNarrow(acc);
            end
        end
        for (int r = 0; r < HIDDEN_SZ; r++)
        begin
            inputTerm  = floorNarrow(longint'(tanhModel(pre[0][r])) * sigmoidModel(pre[1][r]));
            forgetTerm = floorNarrow(longint'(modelCell[r]) * sigmoidModel(pre[2][r]));
            modelCell[r]   = clampToWord(longint'(inputTerm) + forgetTerm);
            modelHidden[r] = floorNarrow(longint'(tanhModel(modelCell[r]))
                * sigmoidModel(pre[3][r]));
        end
    endtask

    task automatic loadWeights(input int limit, input bit checkIdle);
        int value;
        for (int g = 0; g < 4; g++)
            for (int r = 0; r < HIDDEN_SZ; r++)
                for (int c = 0; c < COLUMNS; c++)
                begin
                    @(negedge clock);
                    if (checkIdle)
                    begin
                        checkValue(0, dataoutReady, "dataoutReady before first sample");
                        for (int k = 0; k < HIDDEN_SZ; k++)
                            checkValue(0, outputVec[k], $sformatf("outputVec[%0d] idle", k));
                    end
                    value                 = randomRange(limit);
                    modelWeights[g][r][c] = value;
                    weightWrite           = 1'b1;
                    weightGate            = gateIndexT'(g);
                    weightRow             = ROW_BITS'(r);
                    weightColumn          = COLUMN_BITS'(c);
                    weightData            = fixedT'(value);
                end
        @(negedge clock);
        weightWrite = 1'b0;
    endtask

    // Extra pulses land while the producer is busy and must be dropped
    task automatic runStep(input int inputLimit, input bit extraPulses);
        int latency;
        @(negedge clock);
        for (int c = 0; c < INPUT_SZ; c++)
        begin
            stimulus[c] = randomRange(inputLimit);
            inputVec[c] = fixedT'(stimulus[c]);
        end
        newSample = 1'b1;
        modelStep();
        @(negedge clock);
        newSample = 1'b0;
        latency   = 0;
        while (!dataoutReady)
        begin
            @(negedge clock);
            latency++;
            newSample = extraPulses && (latency == 2 || latency == 5);
        end
        checkValue(LATENCY, latency, "dataoutReady latency");
        for (int r = 0; r < HIDDEN_SZ; r++)
            checkValue(modelHidden[r], outputVec[r], $sformatf("outputVec[%0d]", r));
        @(negedge clock);
        checkValue(0, dataoutReady, "dataoutReady longer than one cycle");
        if (extraPulses)
        begin
            repeat (LATENCY)
            begin
                @(negedge clock);
                checkValue(0, dataoutReady, "dataoutReady from ignored newSample");
            end
        end
    endtask

    task automatic clearRecurrentState();
        @(negedge clock);
        clearState = 1'b1;
        @(negedge clock);
        clearState = 1'b0;
        for (int r = 0; r < HIDDEN_SZ; r++)
        begin
            modelCell[r]   = 0;
            modelHidden[r] = 0;
            checkValue(0, outputVec[r], $sformatf("outputVec[%0d] after clear", r));
        end
    endtask

    always @(posedge clock)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $fatal(1, "Timeout");
        end
    end

    initial
    begin
        void'($urandom(19));
        newSample    = 1'b0;
        clearState   = 1'b0;
        weightWrite  = 1'b0;
        weightGate   = gateZ;
        weightRow    = '0;
        weightColumn = '0;
        weightData   = '0;
        inputVec     = '{default: '0};
        modelCell    = '{default: 0};
        modelHidden  = '{default: 0};
        @(negedge clock);
        while (reset)
            @(negedge clock);

        // Small weights, first step from zero state, then a recurrent run
        loadWeights(UNIT, 1'b1);
        runStep(UNIT, 1'b0);
        repeat (10) runStep(2 * UNIT, 1'b0);

        // Full-range weights and inputs drive the clamps
        loadWeights(WORD_MAX, 1'b0);
        repeat (4) runStep(WORD_MAX, 1'b0);

        clearRecurrentState();
        runStep(WORD_MAX, 1'b0);
        runStep(UNIT, 1'b0);
        clearRecurrentState();
        runStep(UNIT, 1'b0);

        repeat (2) runStep(UNIT, 1'b1);

        $display("TB PASSED");
        $finish;
    end

endmodule

/* verification/clockGen.sv */
`timescale 1ns/1ps

module clockGen
#(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 2
)
(
    output logic clock,
    output logic reset
);

    initial
    begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // Released on a rising edge so the falling-edge driver sees a settled value
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

/* hdl/lstmCell.sv */
`timescale 1ns/1ps

module lstmCell
    import lstmFixedPkg::*, lstmControlPkg::*;
#(
    parameter int  INPUT_SZ    = 2,
    parameter int  HIDDEN_SZ   = 4,
    localparam int ROW_BITS    = (HIDDEN_SZ > 1) ? $clog2(HIDDEN_SZ) : 1,
    localparam int COLUMN_BITS = $clog2(INPUT_SZ + HIDDEN_SZ + 1)
)
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   newSample,
    input  fixedT                  inputVec [INPUT_SZ],
    input  logic                   clearState,
    input  logic                   weightWrite,
    input  gateIndexT              weightGate,
    input  logic [ROW_BITS-1:0]    weightRow,
    input  logic [COLUMN_BITS-1:0] weightColumn,
    input  fixedT                  weightData,
    output logic                   dataoutReady,
    output fixedT                  outputVec [HIDDEN_SZ]
);

    logic  gatesValid;
    logic  cellValid;
    logic  stateUpdated;
    fixedT gateZ [HIDDEN_SZ];
    fixedT gateI [HIDDEN_SZ];
    fixedT gateF [HIDDEN_SZ];
    fixedT gateO [HIDDEN_SZ];
    fixedT newCell [HIDDEN_SZ];
    fixedT newHidden [HIDDEN_SZ];
    fixedT cellState [HIDDEN_SZ];
    fixedT hiddenState [HIDDEN_SZ];

    gateAccumulator #(
        .INPUT_SZ    (INPUT_SZ),
        .HIDDEN_SZ   (HIDDEN_SZ),
        .ROW_BITS    (ROW_BITS),
        .COLUMN_BITS (COLUMN_BITS)
    ) gateAccumulator_inst (
        .clock        (clock),
        .reset        (reset),
        .newSample    (newSample),
        .inputVec     (inputVec),
        .hiddenState  (hiddenState),
        .weightWrite  (weightWrite),
        .weightGate   (weightGate),
        .weightRow    (weightRow),
        .weightColumn (weightColumn),
        .weightData   (weightData),
        .stateUpdated (stateUpdated),
        .gatesValid   (gatesValid),
        .gateZ        (gateZ),
        .gateI        (gateI),
        .gateF        (gateF),
        .gateO        (gateO)
    );

    cellUpdate #(
        .HIDDEN_SZ (HIDDEN_SZ)
    ) cellUpdate_inst (
        .clock      (clock),
        .reset      (reset),
        .gatesValid (gatesValid),
        .gateZ      (gateZ),
        .gateI      (gateI),
        .gateF      (gateF),
        .gateO      (gateO),
        .cellState  (cellState),
        .cellValid  (cellValid),
        .newCell    (newCell),
        .newHidden  (newHidden)
    );

    cellStateStore #(
        .HIDDEN_SZ (HIDDEN_SZ)
    ) cellStateStore_inst (
        .clock        (clock),
        .reset        (reset),
        .clearState   (clearState),
        .cellValid    (cellValid),
        .newCell      (newCell),
        .newHidden    (newHidden),
        .cellState    (cellState),
        .hiddenState  (hiddenState),
        .stateUpdated (stateUpdated)
    );

    assign dataoutReady = stateUpdated;
    assign outputVec    = hiddenState;

endmodule

/* hdl/cellStateStore.sv */
`timescale 1ns/1ps

module cellStateStore
    import lstmFixedPkg::*;
#(
    parameter int HIDDEN_SZ = 4
)
(
    input  logic  clock,
    input  logic  reset,
    input  logic  clearState,
    input  logic  cellValid,
    input  fixedT newCell [HIDDEN_SZ],
    input  fixedT newHidden [HIDDEN_SZ],
    output fixedT cellState [HIDDEN_SZ],
    output fixedT hiddenState [HIDDEN_SZ],
    output logic  stateUpdated
);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            stateUpdated <= 1'b0;
            cellState    <= '{default: '0};
            hiddenState  <= '{default: '0};
        end
        else
        begin
            stateUpdated <= cellValid;
            if (clearState)
            begin
                cellState   <= '{default: '0};
                hiddenState <= '{default: '0};
            end
            else if (cellValid)
            begin
                cellState   <= newCell;
                hiddenState <= newHidden;
            end
        end
    end

    // A clear landing on a write back would lose the sample
    assert property (@(posedge clock) disable iff (reset) !(clearState && cellValid));

endmodule

/* hdl/cellUpdate.sv */
`timescale 1ns/1ps

module cellUpdate
    import lstmFixedPkg::*, lstmControlPkg::*;
#(
    parameter int HIDDEN_SZ = 4
)
(
    input  logic  clock,
    input  logic  reset,
    input  logic  gatesValid,
    input  fixedT gateZ [HIDDEN_SZ],
    input  fixedT gateI [HIDDEN_SZ],
    input  fixedT gateF [HIDDEN_SZ],
    input  fixedT gateO [HIDDEN_SZ],
    input  fixedT cellState [HIDDEN_SZ],
    output logic  cellValid,
    output fixedT newCell [HIDDEN_SZ],
    output fixedT newHidden [HIDDEN_SZ]
);

    updatePhaseT phase;
    fixedT       operandA [HIDDEN_SZ];
    fixedT       operandB [HIDDEN_SZ];
    productT     bankProduct [HIDDEN_SZ];
    fixedT       bankResult [HIDDEN_SZ];
    fixedT       inputTerm [HIDDEN_SZ];
    fixedT       forgetTerm [HIDDEN_SZ];
    fixedT       cellNext [HIDDEN_SZ];

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            phase <= phaseIdle;
        end
        else
        begin
            case (phase)
                phaseIdle:
                begin
                    if (gatesValid)
                        phase <= phaseInputProduct;
                end
                phaseInputProduct:  phase <= phaseForgetProduct;
                phaseForgetProduct: phase <= phaseCellSum;
                phaseCellSum:       phase <= phaseOutputProduct;
                default:            phase <= phaseIdle;
            endcase
        end
    end

    // One multiplier per row, operands picked by phase
    for (genvar r = 0; r < HIDDEN_SZ; r++)
    begin : multiplierRow
        always_comb
        begin
            case (phase)
                phaseInputProduct:
                begin
                    operandA[r] = hardTanh(gateZ[r]);
                    operandB[r] = hardSigmoid(gateI[r]);
                end
                phaseForgetProduct:
                begin
                    operandA[r] = cellState[r];
                    operandB[r] = hardSigmoid(gateF[r]);
                end
                phaseOutputProduct:
                begin
                    operandA[r] = hardTanh(cellNext[r]);
                    operandB[r] = hardSigmoid(gateO[r]);
                end
                default:
                begin
                    operandA[r] = '0;
                    operandB[r] = '0;
                end
            endcase
        end

        assign bankProduct[r] = productT'(operandA[r] * operandB[r]);
        assign bankResult[r]  = narrowProduct(accumulatorT'(bankProduct[r]));

        always_ff @(posedge clock)
        begin
            if (phase == phaseInputProduct)
                inputTerm[r] <= bankResult[r];
            if (phase == phaseForgetProduct)
                forgetTerm[r] <= bankResult[r];
            if (phase == phaseCellSum)
                cellNext[r] <= saturateFixed(accumulatorT'(inputTerm[r])
                    + accumulatorT'(forgetTerm[r]));
        end
    end

    // Hidden value comes straight off the bank in the last phase
    assign cellValid = (phase == phaseOutputProduct);
    assign newCell   = cellNext;
    assign newHidden = bankResult;

    assert property (@(posedge clock) disable iff (reset) gatesValid |-> phase == phaseIdle);

endmodule

/* hdl/gateAccumulator.sv */
`timescale 1ns/1ps

module gateAccumulator
    import lstmFixedPkg::*, lstmControlPkg::*;
#(
    parameter int INPUT_SZ    = 2,
    parameter int HIDDEN_SZ   = 4,
    parameter int ROW_BITS    = 2,
    parameter int COLUMN_BITS = 3
)
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   newSample,
    input  fixedT                  inputVec [INPUT_SZ],
    input  fixedT                  hiddenState [HIDDEN_SZ],
    input  logic                   weightWrite,
    input  gateIndexT              weightGate,
    input  logic [ROW_BITS-1:0]    weightRow,
    input  logic [COLUMN_BITS-1:0] weightColumn,
    input  fixedT                  weightData,
    input  logic                   stateUpdated,
    output logic                   gatesValid,
    output fixedT                  gateZ [HIDDEN_SZ],
    output fixedT                  gateI [HIDDEN_SZ],
    output fixedT                  gateF [HIDDEN_SZ],
    output fixedT                  gateO [HIDDEN_SZ]
);

    localparam int COLUMNS     = INPUT_SZ + HIDDEN_SZ + 1;
    localparam int BIAS_COLUMN = COLUMNS - 1;
    localparam logic [COLUMN_BITS-1:0] LAST_COLUMN = COLUMN_BITS'(COLUMNS - 2);

    // Per gate and row: input weights, recurrent weights, then the bias
    fixedT                  weights [4][HIDDEN_SZ][COLUMNS];
    accumulatorT            sums [4][HIDDEN_SZ];
    fixedT                  operand;
    logic [COLUMN_BITS-1:0] columnCount;
    logic                   busy;
    logic                   running;
    logic                   narrowNow;
    logic                   accept;

    assign accept = newSample && !busy;

    // Input columns first, then the previous hidden state
    always_comb
    begin
        operand = '0;
        for (int c = 0; c < INPUT_SZ; c++)
        begin
            if (columnCount == COLUMN_BITS'(c))
                operand = inputVec[c];
        end
        for (int c = 0; c < HIDDEN_SZ; c++)
        begin
            if (columnCount == COLUMN_BITS'(INPUT_SZ + c))
                operand = hiddenState[c];
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            busy        <= 1'b0;
            running     <= 1'b0;
            narrowNow   <= 1'b0;
            gatesValid  <= 1'b0;
            columnCount <= '0;
        end
        else
        begin
            narrowNow  <= running && (columnCount == LAST_COLUMN);
            gatesValid <= narrowNow;
            if (accept)
            begin
                busy        <= 1'b1;
                running     <= 1'b1;
                columnCount <= '0;
            end
            else if (running)
            begin
                if (columnCount == LAST_COLUMN)
                    running <= 1'b0;
                columnCount <= columnCount + 1'b1;
            end
            // Stay busy until the recurrent state has been written back
            if (stateUpdated)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int g = 0; g < 4; g++)
                for (int r = 0; r < HIDDEN_SZ; r++)
                    for (int c = 0; c < COLUMNS; c++)
                        weights[g][r][c] <= '0;
        end
        else if (weightWrite)
        begin
            weights[weightGate][weightRow][weightColumn] <= weightData;
        end
    end

    for (genvar g = 0; g < 4; g++)
    begin : gateBank
        for (genvar r = 0; r < HIDDEN_SZ; r++)
        begin : rowBank
            always_ff @(posedge clock)
            begin
                if (accept)
                    sums[g][r] <= accumulatorT'(weights[g][r][BIAS_COLUMN]) <<< FRACTION_BITS;
                else if (running)
                    sums[g][r] <= sums[g][r]
                        + accumulatorT'(productT'(weights[g][r][columnCount] * operand));
            end
        end
    end

    for (genvar r = 0; r < HIDDEN_SZ; r++)
    begin : narrowRow
        always_ff @(posedge clock)
        begin
            if (narrowNow)
            begin
                gateZ[r] <= narrowProduct(sums[lstmControlPkg::gateZ][r]);
                gateI[r] <= narrowProduct(sums[lstmControlPkg::gateI][r]);
                gateF[r] <= narrowProduct(sums[lstmControlPkg::gateF][r]);
                gateO[r] <= narrowProduct(sums[lstmControlPkg::gateO][r]);
            end
        end
    end

    assert property (@(posedge clock) disable iff (reset) gatesValid |=> !gatesValid);

    // A new sample starts only once the previous column walk has finished
    assert property (@(posedge clock) disable iff (reset)
        accept |-> (!running && !narrowNow && !gatesValid));

endmodule

/* hdl/lstmControlPkg.sv */
package lstmControlPkg;

    // Gate order in the weight store and the accumulator bank
    typedef enum logic [1:0]
    {
        gateZ = 2'd0,
        gateI = 2'd1,
        gateF = 2'd2,
        gateO = 2'd3
    } gateIndexT;

    // Elementwise stage, one phase per cycle
    typedef enum logic [2:0]
    {
        phaseIdle          = 3'd0,
        phaseInputProduct  = 3'd1,
        phaseForgetProduct = 3'd2,
        phaseCellSum       = 3'd3,
        phaseOutputProduct = 3'd4
    } updatePhaseT;

endpackage

/* hdl/lstmFixedPkg.sv */
package lstmFixedPkg;

    localparam int INTEGER_BITS  = 6;
    localparam int FRACTION_BITS = 11;
    localparam int FIXED_WIDTH   = INTEGER_BITS + FRACTION_BITS + 1;
    localparam int FIXED_ONE     = 1 << FRACTION_BITS;
    localparam int FIXED_HALF    = FIXED_ONE / 2;
    localparam int FIXED_MAX     = (1 << (FIXED_WIDTH - 1)) - 1;
    localparam int FIXED_MIN     = -(1 << (FIXED_WIDTH - 1));

    typedef logic signed [FIXED_WIDTH-1:0]       fixedT;
    typedef logic signed [2*FIXED_WIDTH-1:0]     productT;
    // Eight guard bits cover the column sum of the largest layer
    typedef logic signed [2*FIXED_WIDTH+7:0]     accumulatorT;

    function automatic fixedT saturateFixed(input accumulatorT value);
        if (value > accumulatorT'(FIXED_MAX))
            return fixedT'(FIXED_MAX);
        if (value < accumulatorT'(FIXED_MIN))
            return fixedT'(FIXED_MIN);
        return fixedT'(value);
    endfunction

    // Floor toward minus infinity, then clamp
    function automatic fixedT narrowProduct(input accumulatorT value);
        return saturateFixed(value >>> FRACTION_BITS);
    endfunction

    // Slope 1/4 through 0.5, flat outside
    function automatic fixedT hardSigmoid(input fixedT x);
        accumulatorT scaled;
        scaled = (accumulatorT'(x) >>> 2) + accumulatorT'(FIXED_HALF);
        if (scaled < accumulatorT'(0))
            return '0;
        if (scaled > accumulatorT'(FIXED_ONE))
            return fixedT'(FIXED_ONE);
        return fixedT'(scaled);
    endfunction

    function automatic fixedT hardTanh(input fixedT x);
        if (x > fixedT'(FIXED_ONE))
            return fixedT'(FIXED_ONE);
        if (x < fixedT'(-FIXED_ONE))
            return fixedT'(-FIXED_ONE);
        return x;
    endfunction

endpackage
